// ==== build.f ====
noc_pkg.sv
noc_apb_config.sv
noc_sim_ctrl.sv
noc_traffic_source.sv
noc_router.sv
noc_top.sv
noc_assertions.sv
tb_noc.sv

// ==== Bender.yml ====
package:
  name: noc_ring

sources:
  - noc_pkg.sv
  - noc_apb_config.sv
  - noc_sim_ctrl.sv
  - noc_traffic_source.sv
  - noc_router.sv
  - noc_top.sv
  - target: simulation
    files:
      - noc_assertions.sv
      - tb_noc.sv

// ==== tb_noc.sv ====
`timescale 1ns/1ps

module tb_noc;

    localparam time HALF_PERIOD = 50ns;
    localparam time SAMPLE_DLY  = 25ns;   // mid low phase where outputs have settled
    localparam int  END_TIMEOUT = 2000;
    localparam int  RDY_TIMEOUT = 16;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        sim_end;

    int          errors;
    int          checks;
    integer      seed;
    logic [noc_pkg::COUNT_W-1:0] exp_rx [noc_pkg::NUM_NODES];   // running totals per node

    noc_top dut0 (
        .clk(clk), .reset(reset),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .sim_end_o(sim_end)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic compare_data(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] t=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input logic [noc_pkg::COUNT_W-1:0] got,
                                 input logic [noc_pkg::COUNT_W-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] t=%0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    // one transfer with its setup and access phases
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        int waits;
        waits = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(SAMPLE_DLY);
        while (!pready && waits < RDY_TIMEOUT)
        begin
            @(negedge clk);
            #(SAMPLE_DLY);
            waits++;
        end
        if (!pready)
        begin
            errors++;
            $display("APB transfer to 0x%02h got no pready_o within %0d clocks", addr, waits);
        end
        rdata = prdata;
        compare_flag($sformatf("pslverr_o at 0x%02h", addr), pslverr, exp_err);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        apb_xfer(1'b0, addr, 32'h0, 1'b0, rd);
        compare_data(name, rd, exp);
    endtask

    function automatic logic [31:0] route_word(input int node, input int dest, input logic port);
        noc_pkg::cfg_word_u w;
        w            = '0;
        w.route.node = noc_pkg::NODE_W'(node);
        w.route.dest = noc_pkg::NODE_W'(dest);
        w.route.port = port;
        return w;
    endfunction

    function automatic logic [31:0] pkt_word(input int src, input int dest, input int nflit);
        noc_pkg::cfg_word_u w;
        w           = '0;
        w.pkt.node  = noc_pkg::NODE_W'(src);
        w.pkt.dest  = noc_pkg::NODE_W'(dest);
        w.pkt.nflit = noc_pkg::NFLIT_W'(nflit);
        return w;
    endfunction

    task automatic wait_sim_end(input string what);
        int n;
        n = 0;
        while (!sim_end && n < END_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!sim_end)
        begin
            errors++;
            $display("timeout: %s did not raise sim_end_o within %0d clocks", what, END_TIMEOUT);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    endtask

    task automatic run_to_end(input string what);
        apb_write(noc_pkg::ADDR_CTRL, 32'h1, 1'b0);
        wait_sim_end(what);
        read_check("status", noc_pkg::ADDR_CTRL, 32'h2);   // ended and not running
    endtask

    task automatic check_counts();
        logic [31:0] rd;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++)
        begin
            apb_xfer(1'b0, noc_pkg::ADDR_RX_BASE + 8'(4 * n), 32'h0, 1'b0, rd);
            compare_count($sformatf("rx_count[%0d]", n), rd[noc_pkg::COUNT_W-1:0], exp_rx[n]);
        end
    endtask

    task automatic add_packet(input int src, input int dest, input int nflit);
        apb_write(noc_pkg::ADDR_PKT, pkt_word(src, dest, nflit), 1'b0);
        exp_rx[dest] = exp_rx[dest] + noc_pkg::COUNT_W'(nflit);
    endtask

    task automatic test_reset_state();
        read_check("status", noc_pkg::ADDR_CTRL, 32'h0);
        read_check("cycles", noc_pkg::ADDR_CYCLES, 32'h0);
        check_counts();
        compare_flag("sim_end_o", sim_end, 1'b0);
    endtask

    // eject at the destination and pass everything else around the ring
    task automatic load_routes();
        for (int n = 0; n < noc_pkg::NUM_NODES; n++)
            for (int d = 0; d < noc_pkg::NUM_NODES; d++)
                apb_write(noc_pkg::ADDR_ROUTE,
                          route_word(n, d, (d == n) ? noc_pkg::PORT_EJECT : noc_pkg::PORT_RING),
                          1'b0);
    endtask

    task automatic test_empty_run();
        run_to_end("empty run");
        compare_flag("sim_end_o", sim_end, 1'b1);
        read_check("cycles", noc_pkg::ADDR_CYCLES, 32'h0);
        check_counts();
    endtask

    task automatic test_apb_errors();
        logic [31:0] rd;
        apb_xfer(1'b0, 8'h08, 32'h0, 1'b1, rd);              // unmapped
        apb_write(noc_pkg::ADDR_CYCLES, 32'h5, 1'b1);        // read only
        for (int i = 0; i < noc_pkg::QUEUE_DEPTH; i++)
            add_packet(2, 0, 2);
        apb_write(noc_pkg::ADDR_PKT, pkt_word(2, 0, 2), 1'b1);   // queue full
        run_to_end("full queue run");
        check_counts();
        // config writes while running must bounce
        add_packet(1, 3, 6);
        apb_write(noc_pkg::ADDR_CTRL, 32'h1, 1'b0);
        read_check("status", noc_pkg::ADDR_CTRL, 32'h1);
        apb_write(noc_pkg::ADDR_PKT, pkt_word(1, 1, 5), 1'b1);
        apb_write(noc_pkg::ADDR_ROUTE, route_word(3, 3, noc_pkg::PORT_RING), 1'b1);
        wait_sim_end("run with rejected writes");
        check_counts();
    endtask

    task automatic test_single_packet();
        add_packet(0, 2, 3);
        run_to_end("single packet");
        check_counts();
    endtask

    task automatic test_random_traffic();
        int queued [noc_pkg::NUM_NODES];
        int src;
        int dst;
        int nf;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++)
            queued[n] = 0;
        for (int i = 0; i < 20; i++)
        begin
            src = $unsigned($random(seed)) % noc_pkg::NUM_NODES;
            while (queued[src] == noc_pkg::QUEUE_DEPTH)
                src = (src + 1) % noc_pkg::NUM_NODES;
            dst = $unsigned($random(seed)) % noc_pkg::NUM_NODES;
            nf  = $unsigned($random(seed)) % 15 + 1;
            queued[src]++;
            add_packet(src, dst, nf);
        end
        run_to_end("random traffic");
        check_counts();
    endtask

    initial
    begin
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        errors  = 0;
        checks  = 0;
        seed    = 8211;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++)
            exp_rx[n] = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        load_routes();
        test_empty_run();
        test_apb_errors();
        test_single_packet();
        test_random_traffic();

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.u_assert.fails);
        if (errors == 0 && dut0.u_assert.fails == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== noc_assertions.sv ====
`timescale 1ns/1ps

module noc_assertions
(
    input logic        clk,
    input logic        reset,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pwrite_i,
    input logic [7:0]  paddr_i,
    input logic [31:0] pwdata_i,
    input logic        pready_o,
    input logic        pslverr_o,
    input logic        sim_end_o
);

    int   fails = 0;
    logic start_wr;

    assign start_wr = psel_i && penable_i && pwrite_i &&
                      (paddr_i == noc_pkg::ADDR_CTRL) && pwdata_i[0];

    a_ready: assert property (@(posedge clk) disable iff (reset) pready_o)
        else
        begin
            fails++;
            $error("pready_o dropped");
        end

    a_err_access: assert property (@(posedge clk) disable iff (reset)
                                   pslverr_o |-> (psel_i && penable_i))
        else
        begin
            fails++;
            $error("pslverr_o outside an access phase");
        end

    a_no_rise_on_start: assert property (@(posedge clk) disable iff (reset)
                                         $rose(sim_end_o) |-> !$past(start_wr))
        else
        begin
            fails++;
            $error("sim_end_o rose on a start write");
        end

    // held until the next start
    a_end_sticky: assert property (@(posedge clk) disable iff (reset)
                                   (sim_end_o && !start_wr) |=> sim_end_o)
        else
        begin
            fails++;
            $error("sim_end_o fell without a start");
        end

endmodule

bind noc_top noc_assertions u_assert (.*);

// ==== noc_top.sv ====
`timescale 1ns/1ps

module noc_top
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic        sim_end_o
);

    noc_pkg::cfg_word_u                cfg_word;
    noc_pkg::phase_e                   phase;
    logic [noc_pkg::NUM_NODES-1:0]     route_we;
    logic [noc_pkg::NUM_NODES-1:0]     pkt_push;
    logic [noc_pkg::NUM_NODES-1:0]     queue_full;
    logic [noc_pkg::NUM_NODES-1:0]     node_idle;
    logic [noc_pkg::NUM_NODES-1:0]     src_idle;
    logic [noc_pkg::NUM_NODES-1:0]     rtr_idle;
    logic [noc_pkg::NUM_NODES-1:0]     inj_take;
    logic [noc_pkg::COUNT_W-1:0]       rx_count [noc_pkg::NUM_NODES];
    logic [noc_pkg::COUNT_W-1:0]       cycles;
    logic                              start;
    logic                              running;
    logic                              ended;
    noc_pkg::flit_t                    ring_link [noc_pkg::NUM_NODES];   // out of router n
    noc_pkg::flit_t                    inj_flit [noc_pkg::NUM_NODES];

    noc_apb_config u_apb (
        .clk(clk), .reset(reset),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .queue_full_i(queue_full), .running_i(running), .ended_i(ended),
        .cycles_i(cycles), .rx_count_i(rx_count),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .cfg_word_o(cfg_word), .route_we_o(route_we), .pkt_push_o(pkt_push),
        .start_o(start)
    );

    noc_sim_ctrl u_ctrl (
        .clk(clk), .reset(reset), .start_i(start), .node_idle_i(node_idle),
        .phase_o(phase), .running_o(running), .ended_o(ended),
        .sim_end_o(sim_end_o), .cycles_o(cycles)
    );

    for (genvar n = 0; n < noc_pkg::NUM_NODES; n++)
    begin : g_node
        noc_traffic_source u_src (
            .clk(clk), .reset(reset), .push_i(pkt_push[n]), .cfg_word_i(cfg_word),
            .inj_take_i(inj_take[n]), .queue_full_o(queue_full[n]),
            .inj_flit_o(inj_flit[n]), .src_idle_o(src_idle[n])
        );

        // upstream neighbour feeds this router
        noc_router #(.NODE_ID(n)) u_rtr (
            .clk(clk), .reset(reset), .phase_i(phase), .route_we_i(route_we[n]),
            .cfg_word_i(cfg_word),
            .ring_in_i(ring_link[(n + noc_pkg::NUM_NODES - 1) % noc_pkg::NUM_NODES]),
            .inj_flit_i(inj_flit[n]), .ring_out_o(ring_link[n]),
            .inj_take_o(inj_take[n]), .rx_count_o(rx_count[n]),
            .router_idle_o(rtr_idle[n])
        );

        assign node_idle[n] = src_idle[n] && rtr_idle[n];
    end

endmodule

// ==== noc_router.sv ====
`timescale 1ns/1ps

module noc_router
#(
    parameter int NODE_ID = 0
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  noc_pkg::phase_e             phase_i,
    input  logic                        route_we_i,
    input  noc_pkg::cfg_word_u          cfg_word_i,
    input  noc_pkg::flit_t              ring_in_i,
    input  noc_pkg::flit_t              inj_flit_i,
    output noc_pkg::flit_t              ring_out_o,
    output logic                        inj_take_o,
    output logic [noc_pkg::COUNT_W-1:0] rx_count_o,
    output logic                        router_idle_o
);

    noc_pkg::flit_t stage_q;
    logic           rt_port [noc_pkg::NUM_NODES];   // dest -> output port
    logic           tbl_we;
    logic           ring_port;
    logic           inj_port;
    logic           inj_ok;
    logic           ring_gnt_q;
    logic           ring_port_q;
    logic           inj_gnt_q;
    logic           inj_port_q;
    logic           eject_any;

    assign tbl_we = route_we_i && (cfg_word_i.route.node == noc_pkg::NODE_W'(NODE_ID));

    // lookups for the two candidates
    assign ring_port = rt_port[stage_q.dest];
    assign inj_port  = rt_port[inj_flit_i.dest];
    assign inj_ok    = inj_flit_i.valid && !(stage_q.valid && ring_port == inj_port);

    assign eject_any = (ring_gnt_q && ring_port_q == noc_pkg::PORT_EJECT) ||
                       (inj_gnt_q && inj_port_q == noc_pkg::PORT_EJECT);

    assign inj_take_o    = (phase_i == noc_pkg::PH_MOVE) && inj_gnt_q;
    assign router_idle_o = !stage_q.valid && !ring_out_o.valid;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int d = 0; d < noc_pkg::NUM_NODES; d++)
                rt_port[d] <= noc_pkg::PORT_RING;
        end
        else if (tbl_we)
            rt_port[cfg_word_i.route.dest] <= cfg_word_i.route.port;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            stage_q     <= '0;
            ring_out_o  <= '0;
            ring_gnt_q  <= 1'b0;
            ring_port_q <= noc_pkg::PORT_RING;
            inj_gnt_q   <= 1'b0;
            inj_port_q  <= noc_pkg::PORT_RING;
            rx_count_o  <= '0;
        end
        else
        begin
            case (phase_i)
                noc_pkg::PH_LOAD:
                    stage_q <= ring_in_i;
                noc_pkg::PH_ARB:
                begin
                    ring_gnt_q  <= stage_q.valid;   // ring traffic never waits
                    ring_port_q <= ring_port;
                    inj_gnt_q   <= inj_ok;
                    inj_port_q  <= inj_port;
                end
                noc_pkg::PH_MOVE:
                begin
                    ring_out_o <= '0;
                    if (ring_gnt_q && ring_port_q == noc_pkg::PORT_RING)
                        ring_out_o <= stage_q;
                    else if (inj_gnt_q && inj_port_q == noc_pkg::PORT_RING)
                        ring_out_o <= inj_flit_i;
                    if (eject_any)
                        rx_count_o <= rx_count_o + 1'b1;
                    stage_q    <= '0;
                    ring_gnt_q <= 1'b0;
                    inj_gnt_q  <= 1'b0;
                end
                default:
                begin
                    // nothing moves in the check phase
                end
            endcase
        end
    end

endmodule

// ==== noc_traffic_source.sv ====
`timescale 1ns/1ps

module noc_traffic_source
(
    input  logic               clk,
    input  logic               reset,
    input  logic               push_i,
    input  noc_pkg::cfg_word_u cfg_word_i,
    input  logic               inj_take_i,
    output logic               queue_full_o,
    output noc_pkg::flit_t     inj_flit_o,
    output logic               src_idle_o
);

    noc_pkg::pkt_desc_t              queue_mem [noc_pkg::QUEUE_DEPTH];
    noc_pkg::pkt_desc_t              head;
    logic [noc_pkg::QPTR_W-1:0]      wr_ptr;
    logic [noc_pkg::QPTR_W-1:0]      rd_ptr;
    logic [noc_pkg::QCNT_W-1:0]      count;
    logic [noc_pkg::NFLIT_W-1:0]     rem_q;   // 0 means reload from head
    logic [noc_pkg::NFLIT_W-1:0]     rem_eff;
    logic                            last_flit;
    logic                            do_push;
    logic                            do_pop;

    assign head         = queue_mem[rd_ptr];
    assign queue_full_o = (count == noc_pkg::QCNT_W'(noc_pkg::QUEUE_DEPTH));
    assign src_idle_o   = (count == '0);

    assign rem_eff   = (rem_q == '0) ? head.nflit : rem_q;
    assign last_flit = (rem_eff <= noc_pkg::NFLIT_W'(1));   // zero count sends one flit
    assign do_push   = push_i && !queue_full_o;
    assign do_pop    = inj_take_i && !src_idle_o && last_flit;

    always_comb
    begin
        inj_flit_o.valid = !src_idle_o;
        inj_flit_o.tail  = !src_idle_o && last_flit;
        inj_flit_o.dest  = src_idle_o ? '0 : head.dest;
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            queue_mem[wr_ptr] <= cfg_word_i.pkt;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rem_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (inj_take_i && !src_idle_o)
            begin
                if (last_flit)
                begin
                    rd_ptr <= rd_ptr + 1'b1;
                    rem_q  <= '0;
                end
                else
                    rem_q <= rem_eff - 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== noc_sim_ctrl.sv ====
`timescale 1ns/1ps

module noc_sim_ctrl
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_i,
    input  logic [noc_pkg::NUM_NODES-1:0] node_idle_i,
    output noc_pkg::phase_e               phase_o,
    output logic                          running_o,
    output logic                          ended_o,
    output logic                          sim_end_o,
    output logic [noc_pkg::COUNT_W-1:0]   cycles_o
);

    logic end_q;
    logic all_idle;

    assign all_idle  = &node_idle_i;
    assign ended_o   = end_q;
    assign sim_end_o = end_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase_o   <= noc_pkg::PH_CHECK;   // parked where nothing acts
            running_o <= 1'b0;
            end_q     <= 1'b0;
            cycles_o  <= '0;
        end
        else if (start_i)
        begin
            phase_o   <= noc_pkg::PH_LOAD;
            running_o <= 1'b1;
            end_q     <= 1'b0;
            cycles_o  <= '0;
        end
        else if (running_o)
        begin
            unique case (phase_o)
                noc_pkg::PH_LOAD:  phase_o <= noc_pkg::PH_ARB;
                noc_pkg::PH_ARB:   phase_o <= noc_pkg::PH_MOVE;
                noc_pkg::PH_MOVE:  phase_o <= noc_pkg::PH_CHECK;
                noc_pkg::PH_CHECK:
                begin
                    if (all_idle)
                    begin
                        running_o <= 1'b0;   // phase stays parked in check
                        end_q     <= 1'b1;
                    end
                    else
                    begin
                        cycles_o <= cycles_o + 1'b1;
                        phase_o  <= noc_pkg::PH_LOAD;
                    end
                end
            endcase
        end
    end

endmodule

// ==== noc_apb_config.sv ====
`timescale 1ns/1ps

module noc_apb_config
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [7:0]                  paddr_i,
    input  logic [31:0]                 pwdata_i,
    input  logic [noc_pkg::NUM_NODES-1:0] queue_full_i,
    input  logic                        running_i,
    input  logic                        ended_i,
    input  logic [noc_pkg::COUNT_W-1:0] cycles_i,
    input  logic [noc_pkg::COUNT_W-1:0] rx_count_i [noc_pkg::NUM_NODES],
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output noc_pkg::cfg_word_u          cfg_word_o,
    output logic [noc_pkg::NUM_NODES-1:0] route_we_o,
    output logic [noc_pkg::NUM_NODES-1:0] pkt_push_o,
    output logic                        start_o
);

    noc_pkg::cfg_word_u              wr_word;
    logic                            access;
    logic                            wr_ok;
    logic                            err;
    logic                            hit_rx;
    logic [noc_pkg::NODE_W-1:0]      rx_idx;

    assign wr_word  = pwdata_i;
    assign access   = psel_i && penable_i;
    assign pready_o = 1'b1;   // no wait states

    // word aligned count window 0x20..0x2c
    assign hit_rx = (paddr_i[7:noc_pkg::NODE_W+2] ==
                     noc_pkg::ADDR_RX_BASE[7:noc_pkg::NODE_W+2]) && (paddr_i[1:0] == 2'b00);
    assign rx_idx = paddr_i[noc_pkg::NODE_W+1:2];

    always_comb
    begin
        err = 1'b0;
        if (hit_rx)
            err = pwrite_i;   // read only
        else
        begin
            case (paddr_i)
                noc_pkg::ADDR_CTRL:   err = 1'b0;
                noc_pkg::ADDR_CYCLES: err = pwrite_i;
                noc_pkg::ADDR_ROUTE:  err = pwrite_i && running_i;
                noc_pkg::ADDR_PKT:    err = pwrite_i &&
                                            (running_i || queue_full_i[wr_word.pkt.node]);
                default:              err = 1'b1;   // unmapped
            endcase
        end
    end

    assign pslverr_o = access && err;
    assign wr_ok     = access && pwrite_i && !err;
    assign start_o   = wr_ok && (paddr_i == noc_pkg::ADDR_CTRL) && pwdata_i[0];

    always_comb
    begin
        prdata_o = '0;
        if (hit_rx)
            prdata_o = 32'(rx_count_i[rx_idx]);
        else if (paddr_i == noc_pkg::ADDR_CTRL)
            prdata_o = {30'b0, ended_i, running_i};
        else if (paddr_i == noc_pkg::ADDR_CYCLES)
            prdata_o = 32'(cycles_i);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            route_we_o <= '0;
            pkt_push_o <= '0;
        end
        else
        begin
            route_we_o <= '0;
            pkt_push_o <= '0;
            if (wr_ok && paddr_i == noc_pkg::ADDR_ROUTE)
                route_we_o[wr_word.route.node] <= 1'b1;
            if (wr_ok && paddr_i == noc_pkg::ADDR_PKT)
                pkt_push_o[wr_word.pkt.node] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_ok && (paddr_i == noc_pkg::ADDR_ROUTE || paddr_i == noc_pkg::ADDR_PKT))
            cfg_word_o <= wr_word;
    end

endmodule

// ==== noc_pkg.sv ====
package noc_pkg;

    localparam int NUM_NODES   = 4;
    localparam int NODE_W      = 2;
    localparam int NFLIT_W     = 4;
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W      = 3;   // index into a source queue
    localparam int QCNT_W      = 4;   // occupancy 0..QUEUE_DEPTH
    localparam int COUNT_W     = 16;

    // router output ports
    localparam logic PORT_EJECT = 1'b0;
    localparam logic PORT_RING  = 1'b1;

    localparam logic [7:0] ADDR_CTRL    = 8'h00;
    localparam logic [7:0] ADDR_CYCLES  = 8'h04;
    localparam logic [7:0] ADDR_ROUTE   = 8'h10;
    localparam logic [7:0] ADDR_PKT     = 8'h14;
    localparam logic [7:0] ADDR_RX_BASE = 8'h20;   // + 4 per node

    typedef struct packed {
        logic              valid;
        logic              tail;
        logic [NODE_W-1:0] dest;
    } flit_t;

    // node and dest sit at the same bits in both views
    typedef struct packed {
        logic [31-2*NODE_W-NFLIT_W:0] rsvd;
        logic [NODE_W-1:0]            node;
        logic [NODE_W-1:0]            dest;
        logic [NFLIT_W-2:0]           pad;
        logic                         port;
    } route_entry_t;

    typedef struct packed {
        logic [31-2*NODE_W-NFLIT_W:0] rsvd;
        logic [NODE_W-1:0]            node;   // source
        logic [NODE_W-1:0]            dest;
        logic [NFLIT_W-1:0]           nflit;
    } pkt_desc_t;

    typedef union packed {
        route_entry_t route;
        pkt_desc_t    pkt;
    } cfg_word_u;

    typedef enum logic [1:0] {PH_LOAD, PH_ARB, PH_MOVE, PH_CHECK} phase_e;

endpackage
